//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cpu
FILELIST = project.f
LOG      = sim.log
OBJ      = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- cpu_alu.sv
// Operand muxes and registered ALU
// Result and status are valid one ready cycle after the operands
`timescale 1ns/10ps

module cpu_alu (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::cpu_state_e state,
    input  cpu_pkg::alu_op_e    op,
    input  logic                load_only,
    input  logic                compare,
    input  logic                backwards,
    input  logic                c,
    input  cpu_pkg::byte_t      regfile,
    input  cpu_pkg::byte_t      pcl,
    input  cpu_pkg::byte_t      abh,
    input  cpu_pkg::byte_t      data_in,
    output cpu_pkg::byte_t      alu_out,
    output logic                co,
    output logic                av,
    output logic                az,
    output logic                an
);

    cpu_pkg::byte_t   ai, bi, bb, res;
    cpu_pkg::alu_op_e alu_op;
    logic             ci;
    logic [8:0]       sum;

    always_comb begin
        ai     = 8'h00;                                 // Default passes data_in through
        bi     = data_in;
        ci     = 1'b0;
        alu_op = cpu_pkg::OP_ADD;
        case (state)
            cpu_pkg::FETCH: begin
                ai     = load_only ? 8'h00 : regfile;
                ci     = compare | (~load_only & c);    // CMP forces carry, loads clear it
                alu_op = op;
            end
            cpu_pkg::REG: begin
                ai     = regfile;
                bi     = 8'h00;
                ci     = (op == cpu_pkg::OP_ADD);       // INX/INY add 1, DEX/DEY add FF
                alu_op = op;
            end
            cpu_pkg::BRA0: begin
                ai = data_in;                           // Offset plus PCL
                bi = pcl;
            end
            cpu_pkg::BRA1: begin
                ai     = abh;                           // Page carry or borrow
                bi     = 8'h00;
                ci     = co;
                alu_op = backwards ? cpu_pkg::OP_SUB : cpu_pkg::OP_ADD;
            end
            default: ;
        endcase
    end

    assign bb  = (alu_op == cpu_pkg::OP_SUB) ? ~bi : bi;
    assign sum = {1'b0, ai} + {1'b0, bb} + {8'b0, ci};

    always_comb begin
        case (alu_op)
            cpu_pkg::OP_OR:  res = ai | bi;
            cpu_pkg::OP_AND: res = ai & bi;
            cpu_pkg::OP_EOR: res = ai ^ bi;
            cpu_pkg::OP_ADD,
            cpu_pkg::OP_SUB: res = sum[7:0];
            default:         res = ai;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_out <= 8'h00;
            co      <= 1'b0;
            av      <= 1'b0;
            az      <= 1'b0;
            an      <= 1'b0;
        end else if (rdy) begin
            alu_out <= res;
            co      <= sum[8];
            av      <= (ai[7] == bb[7]) && (sum[7] != ai[7]);  // Signed overflow
            az      <= (res == 8'h00);
            an      <= res[7];
        end
    end

endmodule

//--- cpu_bus_unit.sv
// Program counter, address generator and write side of the bus
// PC starts at RESET_PC; there is no reset vector fetch
`timescale 1ns/10ps

module cpu_bus_unit #(
    parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::cpu_state_e state,
    input  logic                store,
    input  cpu_pkg::byte_t      regfile,
    input  cpu_pkg::byte_t      alu_out,
    input  logic                co,
    input  logic                backwards,
    input  cpu_pkg::byte_t      data_in,
    output cpu_pkg::addr_t      ab,
    output cpu_pkg::byte_t      data_out,
    output logic                we,
    output cpu_pkg::byte_t      pcl,
    output cpu_pkg::byte_t      abh
);

    cpu_pkg::addr_t pc, pc_temp;
    cpu_pkg::byte_t abl;
    logic           pc_inc;

    always_comb begin
        pc_inc = 1'b0;
        case (state)
            cpu_pkg::JMP1: pc_temp = {data_in, alu_out};
            cpu_pkg::BRA1: pc_temp = {abh, alu_out};
            cpu_pkg::BRA2: pc_temp = {alu_out, pc[7:0]};
            default:       pc_temp = pc;
        endcase
        case (state)
            cpu_pkg::BOOT, cpu_pkg::DECODE, cpu_pkg::ABS0, cpu_pkg::FETCH,
            cpu_pkg::BRA0, cpu_pkg::BRA2, cpu_pkg::JMP1: pc_inc = 1'b1;
            cpu_pkg::BRA1: pc_inc = co ~^ backwards;   // Same page, done
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            pc <= RESET_PC;
        else if (rdy)
            pc <= pc_temp + {15'b0, pc_inc};
    end

    always_comb begin
        case (state)
            cpu_pkg::ZP0:  ab = {cpu_pkg::ZERO_PAGE, data_in};
            cpu_pkg::ABS1,
            cpu_pkg::JMP1: ab = {data_in, alu_out};
            cpu_pkg::BRA1: ab = {abh, alu_out};         // Target in the same page
            cpu_pkg::BRA2: ab = {alu_out, abl};         // Corrected page
            cpu_pkg::REG:  ab = {abh, abl};             // Next opcode, PC already ahead
            default:       ab = pc;
        endcase
    end

    // Previous address, frees the ALU and data_in for the next step
    always_ff @(posedge clk) begin
        if (rdy)
            {abh, abl} <= ab;
    end

    assign pcl      = pc[7:0];
    assign data_out = regfile;
    assign we       = store && (state == cpu_pkg::ZP0 || state == cpu_pkg::ABS1);

    // A store writes for one ready cycle, then the sequencer moves on
    a_we_one_cycle: assert property (@(posedge clk) disable iff (reset)
        (we && rdy) |=> !we)
        else $error("write enable held past its store cycle");

endmodule

//--- cpu_decode.sv
// Opcode decoder, looks at data_in only while state is DECODE
// Unknown opcodes map to REG and run as a two-cycle NOP
`timescale 1ns/10ps

module cpu_decode (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::cpu_state_e state,
    input  cpu_pkg::byte_t      data_in,
    output cpu_pkg::cpu_state_e mode_state,
    output logic                load_reg,
    output logic                store,
    output logic                load_only,
    output logic                compare,
    output logic                adc_sbc,
    output cpu_pkg::alu_op_e    op,
    output cpu_pkg::reg_sel_e   src_reg,
    output cpu_pkg::reg_sel_e   dst_reg,
    output logic [3:0]          cond_code,
    output logic                clc,
    output logic                sec
);

    logic is_imm, is_zp, is_abs;
    logic is_load, is_store, is_adcsbc, is_cmp, is_logic, is_step;
    cpu_pkg::alu_op_e  op_next;
    cpu_pkg::reg_sel_e src_next, dst_next;

    // Addressing mode groups
    assign is_imm = data_in inside {8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
                                    8'hC9};
    assign is_zp  = data_in inside {8'hA5, 8'hA6, 8'hA4, 8'h85, 8'h86, 8'h84, 8'h65, 8'hE5,
                                    8'h25, 8'h05, 8'h45, 8'hC5};
    assign is_abs = data_in inside {8'hAD, 8'hAE, 8'hAC, 8'h8D, 8'h8E, 8'h8C};

    // Instruction groups
    assign is_load   = data_in inside {8'hA9, 8'hA5, 8'hAD, 8'hA2, 8'hA6, 8'hAE, 8'hA0, 8'hA4,
                                       8'hAC};
    assign is_store  = data_in inside {8'h85, 8'h86, 8'h84, 8'h8D, 8'h8E, 8'h8C};
    assign is_adcsbc = data_in inside {8'h69, 8'h65, 8'hE9, 8'hE5};
    assign is_cmp    = data_in inside {8'hC9, 8'hC5};
    assign is_logic  = data_in inside {8'h09, 8'h05, 8'h29, 8'h25, 8'h49, 8'h45};
    assign is_step   = data_in inside {8'hAA, 8'h8A, 8'hA8, 8'h98, 8'hE8, 8'hC8, 8'hCA, 8'h88};

    always_comb begin
        if (data_in[4:0] == 5'b10000) mode_state = cpu_pkg::BRA0;  // Bxx, odd 0 column
        else if (data_in == 8'h4C)    mode_state = cpu_pkg::JMP0;
        else if (is_imm)              mode_state = cpu_pkg::FETCH;
        else if (is_zp)               mode_state = cpu_pkg::ZP0;
        else if (is_abs)              mode_state = cpu_pkg::ABS0;
        else                          mode_state = cpu_pkg::REG;   // Transfers, flags, NOP
    end

    always_comb begin
        if (data_in inside {8'h09, 8'h05})                    op_next = cpu_pkg::OP_OR;
        else if (data_in inside {8'h29, 8'h25})               op_next = cpu_pkg::OP_AND;
        else if (data_in inside {8'h49, 8'h45})               op_next = cpu_pkg::OP_EOR;
        else if (data_in inside {8'hE9, 8'hE5, 8'hC9, 8'hC5, 8'hCA, 8'h88})
            op_next = cpu_pkg::OP_SUB;                                // SBC, CMP, DEX, DEY
        else if (is_load || data_in inside {8'h69, 8'h65, 8'hE8, 8'hC8})
            op_next = cpu_pkg::OP_ADD;                                // Loads add to zero
        else                                                  op_next = cpu_pkg::OP_A;
    end

    always_comb begin
        if (data_in inside {8'hA2, 8'hA6, 8'hAE, 8'hAA, 8'hE8, 8'hCA}) dst_next = cpu_pkg::SEL_X;
        else if (data_in inside {8'hA0, 8'hA4, 8'hAC, 8'hA8, 8'hC8, 8'h88})
            dst_next = cpu_pkg::SEL_Y;
        else dst_next = cpu_pkg::SEL_A;
        if (data_in inside {8'h86, 8'h8E, 8'h8A, 8'hE8, 8'hCA})      src_next = cpu_pkg::SEL_X;
        else if (data_in inside {8'h84, 8'h8C, 8'h98, 8'hC8, 8'h88}) src_next = cpu_pkg::SEL_Y;
        else src_next = cpu_pkg::SEL_A;
    end

    // Control fields live for the whole instruction
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_reg  <= 1'b0;
            store     <= 1'b0;
            load_only <= 1'b0;
            compare   <= 1'b0;
            adc_sbc   <= 1'b0;
            op        <= cpu_pkg::OP_A;
            src_reg   <= cpu_pkg::SEL_A;
            dst_reg   <= cpu_pkg::SEL_A;
            cond_code <= 4'h0;
            clc       <= 1'b0;
            sec       <= 1'b0;
        end else if (rdy && state == cpu_pkg::DECODE) begin
            load_reg  <= is_load | is_adcsbc | is_logic | is_step;
            store     <= is_store;
            load_only <= is_load;
            compare   <= is_cmp;
            adc_sbc   <= is_adcsbc;
            op        <= op_next;
            src_reg   <= src_next;
            dst_reg   <= dst_next;
            cond_code <= data_in[7:4];                  // Flag select and polarity
            clc       <= (data_in == 8'h18);
            sec       <= (data_in == 8'h38);
        end
    end

    a_store_no_load: assert property (@(posedge clk) disable iff (reset) !(store && load_reg))
        else $error("store and load_reg both set");

endmodule

//--- cpu_pkg.sv
// Shared types and constants for the reduced 6502-style core
// Binary arithmetic only; no D or I flag, no stack page
// State and operation encodings are internal and may change

package cpu_pkg;

    typedef logic [7:0]  byte_t;                // Data bus value
    typedef logic [15:0] addr_t;                // Address bus value

    // One path of states per addressing mode
    typedef enum logic [3:0] {
        BOOT,                                   // First fetch after reset
        DECODE,                                 // Opcode on data_in, write back previous result
        FETCH,                                  // Operand on data_in, run ALU op
        REG,                                    // Register-only instruction
        ZP0,                                    // Zero page address on data_in
        ABS0,                                   // Absolute low byte
        ABS1,                                   // Absolute high byte
        BRA0,                                   // Branch offset, add to PCL
        BRA1,                                   // Branch taken, fix up low byte
        BRA2,                                   // Page crossed, fix up high byte
        JMP0,                                   // Jump low byte
        JMP1                                    // Jump high byte
    } cpu_state_e;

    typedef enum logic [2:0] {
        OP_OR,
        OP_AND,
        OP_EOR,
        OP_ADD,
        OP_SUB,                                 // A + ~B + carry
        OP_A                                    // Pass A input
    } alu_op_e;

    typedef enum logic [1:0] {
        SEL_A,
        SEL_X,
        SEL_Y
    } reg_sel_e;

    localparam byte_t ZERO_PAGE = 8'h00;        // High address byte for zp modes

endpackage

//--- cpu_regs_flags.sv
// A, X and Y registers plus the N, Z, C and V flags
// All writes happen in DECODE, for the instruction just finished
`timescale 1ns/10ps

module cpu_regs_flags (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::cpu_state_e state,
    input  logic                load_reg,
    input  cpu_pkg::reg_sel_e   src_reg,
    input  cpu_pkg::reg_sel_e   dst_reg,
    input  logic                adc_sbc,
    input  logic                compare,
    input  logic                clc,
    input  logic                sec,
    input  cpu_pkg::byte_t      alu_out,
    input  logic                co,
    input  logic                av,
    input  logic                az,
    input  logic                an,
    output cpu_pkg::byte_t      regfile,
    output logic                n,
    output logic                z,
    output logic                c,
    output logic                v
);

    cpu_pkg::byte_t    axy [3];                          // Indexed by reg_sel_e
    cpu_pkg::reg_sel_e regsel;
    logic              write_back;

    assign write_back = rdy && (state == cpu_pkg::DECODE);
    assign regsel     = (state == cpu_pkg::DECODE) ? dst_reg : src_reg;
    assign regfile    = axy[regsel];

    always_ff @(posedge clk) begin
        if (write_back && load_reg)
            axy[dst_reg] <= alu_out;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            n <= 1'b0;
            z <= 1'b0;
            c <= 1'b0;
            v <= 1'b0;
        end else if (write_back) begin
            if (load_reg || compare) begin
                n <= an;
                z <= az;
            end
            if (adc_sbc || compare)
                c <= co;
            else if (sec)
                c <= 1'b1;
            else if (clc)
                c <= 1'b0;
            if (adc_sbc)
                v <= av;
        end
    end

endmodule

//--- cpu_sequencer.sv
// Addressing-mode state machine and branch decision
// Everything freezes while rdy is low
`timescale 1ns/10ps

module cpu_sequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                rdy,
    input  cpu_pkg::cpu_state_e mode_state,
    input  logic                store,
    input  logic [3:0]          cond_code,
    input  logic                n,
    input  logic                z,
    input  logic                c,
    input  logic                v,
    input  logic                co,
    input  cpu_pkg::byte_t      data_in,
    output cpu_pkg::cpu_state_e state,
    output logic                backwards
);

    logic flag, cond_true;
    cpu_pkg::cpu_state_e next_state;

    always_comb begin
        case (cond_code[3:2])                           // Opcode bits 7:6 pick the flag
            2'd0:    flag = n;
            2'd1:    flag = v;
            2'd2:    flag = c;
            default: flag = z;
        endcase
        cond_true = (flag == cond_code[1]);             // Bit 5 gives polarity
    end

    always_comb begin
        case (state)
            cpu_pkg::BOOT:   next_state = cpu_pkg::DECODE;
            cpu_pkg::DECODE: next_state = mode_state;
            cpu_pkg::ZP0:    next_state = cpu_pkg::FETCH;
            cpu_pkg::ABS0:   next_state = cpu_pkg::ABS1;
            cpu_pkg::ABS1:   next_state = cpu_pkg::FETCH;
            cpu_pkg::BRA0:   next_state = cond_true ? cpu_pkg::BRA1 : cpu_pkg::DECODE;
            cpu_pkg::BRA1:   next_state = (co ^ backwards) ? cpu_pkg::BRA2 : cpu_pkg::DECODE;
            cpu_pkg::JMP0:   next_state = cpu_pkg::JMP1;
            default:         next_state = cpu_pkg::DECODE;  // FETCH, REG, BRA2, JMP1
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= cpu_pkg::BOOT;
            backwards <= 1'b0;
        end else if (rdy) begin
            state <= next_state;
            if (state == cpu_pkg::BRA0)
                backwards <= data_in[7];                // Offset sign
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(state) && state inside {[cpu_pkg::BOOT:cpu_pkg::JMP1]})
        else $error("sequencer state out of range");

    a_bra2_order: assert property (@(posedge clk) disable iff (reset)
        $rose(state == cpu_pkg::BRA2) |-> $past(state) == cpu_pkg::BRA1)
        else $error("BRA2 entered without BRA1");

    // Decoder and sequencer must agree that jumps and branches never write
    a_no_store_flow: assert property (@(posedge clk) disable iff (reset)
        (state inside {cpu_pkg::BRA0, cpu_pkg::JMP0}) |-> !store)
        else $error("store flag set on branch or jump");

endmodule

//--- cpu_top.sv
// Reduced 6502-style core with separate read and write buses
// data_in carries the byte of the address from the previous ready cycle
// Memory read data must hold while rdy is low
// No IRQ, NMI, stack or decimal mode
`timescale 1ns/10ps

module cpu_top #(
    parameter cpu_pkg::addr_t RESET_PC = 16'h0200
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           rdy,
    input  cpu_pkg::byte_t data_in,
    output cpu_pkg::addr_t ab,
    output cpu_pkg::byte_t data_out,
    output logic           we
);

    cpu_pkg::cpu_state_e state, mode_state;
    cpu_pkg::alu_op_e    op;
    cpu_pkg::reg_sel_e   src_reg, dst_reg;
    cpu_pkg::byte_t      alu_out, regfile, pcl, abh;
    logic [3:0]          cond_code;
    logic load_reg, store, load_only, compare, adc_sbc, clc, sec;
    logic n, z, c, v, co, av, az, an, backwards;

    cpu_sequencer cpu_sequencer_inst (
        .clk, .reset, .rdy, .mode_state, .store, .cond_code,
        .n, .z, .c, .v, .co, .data_in, .state, .backwards
    );

    cpu_decode cpu_decode_inst (
        .clk, .reset, .rdy, .state, .data_in, .mode_state, .load_reg, .store,
        .load_only, .compare, .adc_sbc, .op, .src_reg, .dst_reg, .cond_code, .clc, .sec
    );

    cpu_alu cpu_alu_inst (
        .clk, .reset, .rdy, .state, .op, .load_only, .compare, .backwards, .c,
        .regfile, .pcl, .abh, .data_in, .alu_out, .co, .av, .az, .an
    );

    cpu_regs_flags cpu_regs_flags_inst (
        .clk, .reset, .rdy, .state, .load_reg, .src_reg, .dst_reg, .adc_sbc, .compare,
        .clc, .sec, .alu_out, .co, .av, .az, .an, .regfile, .n, .z, .c, .v
    );

    cpu_bus_unit #(
        .RESET_PC(RESET_PC)
    ) cpu_bus_unit_inst (
        .clk, .reset, .rdy, .state, .store, .regfile, .alu_out, .co, .backwards,
        .data_in, .ab, .data_out, .we, .pcl, .abh
    );

endmodule

//--- project.f
+incdir+.
cpu_pkg.sv
cpu_decode.sv
cpu_sequencer.sv
cpu_alu.sv
cpu_regs_flags.sv
cpu_bus_unit.sv
cpu_top.sv
tb_cpu.sv

//--- tb_program.svh
// Test program and its expected stores, built with a 6502 reference model
// Stores go to zero page from 0x20 and to 0x0600 up; 0xF0 is never written
// Branch tests take a path over a store to 0xF0 when the flag is right

cpu_pkg::addr_t asm_pc;                                 // Assembly location
cpu_pkg::addr_t next_abs;
cpu_pkg::byte_t next_zp, data_zp;
cpu_pkg::byte_t m_a, m_x, m_y;                          // Model registers
logic           m_n, m_z, m_c, m_v;

task automatic put_byte(input cpu_pkg::byte_t b);
    mem[asm_pc] = b;
    asm_pc = asm_pc + 16'd1;
endtask

task automatic put_two(input cpu_pkg::byte_t opc, input cpu_pkg::byte_t arg);
    put_byte(opc);
    put_byte(arg);
endtask

task automatic expect_store(input cpu_pkg::addr_t a, input cpu_pkg::byte_t v);
    expected_we[a]  = 1'b1;
    expected_val[a] = v;
endtask

task automatic store_zp(input cpu_pkg::byte_t opc, input cpu_pkg::byte_t v);
    put_two(opc, next_zp);
    expect_store({8'h00, next_zp}, v);
    next_zp = next_zp + 8'd1;
endtask

task automatic store_abs(input cpu_pkg::byte_t opc, input cpu_pkg::byte_t v);
    put_byte(opc);
    put_two(next_abs[7:0], next_abs[15:8]);
    expect_store(next_abs, v);
    next_abs = next_abs + 16'd1;
endtask

task automatic model_nz(input cpu_pkg::byte_t r);
    m_n = r[7];
    m_z = (r == 8'h00);
endtask

// Binary add with carry; subtract passes the inverted operand
task automatic model_add(input cpu_pkg::byte_t b);
    logic [8:0] s;
    s   = {1'b0, m_a} + {1'b0, b} + {8'b0, m_c};
    m_v = (m_a[7] == b[7]) && (s[7] != m_a[7]);
    m_c = s[8];
    m_a = s[7:0];
    model_nz(m_a);
endtask

// Flag 0..3 is N, V, C, Z; not-taken branch then store, taken branch over a bad store
task automatic check_flag(input logic [1:0] f, input logic val);
    cpu_pkg::byte_t taken;
    taken = {f, 6'b010000} | (val ? 8'h20 : 8'h00);
    put_two(taken ^ 8'h20, 8'h02);
    store_zp(8'h85, m_a);
    put_two(taken, 8'h02);
    put_two(8'h85, 8'hF0);
endtask

task automatic check_all_flags();
    check_flag(2'd0, m_n);
    check_flag(2'd1, m_v);
    check_flag(2'd2, m_c);
    check_flag(2'd3, m_z);
endtask

// Immediate or zero-page ALU op after a carry set and a load of A
task automatic alu_case(input cpu_pkg::byte_t opc, input logic carry,
                        input cpu_pkg::byte_t a_val, input cpu_pkg::byte_t b);
    logic [8:0] s;
    put_byte(carry ? 8'h38 : 8'h18);                    // SEC or CLC
    m_c = carry;
    put_two(8'hA9, a_val);
    m_a = a_val;
    if (opc[2]) begin                                   // Zero-page form
        mem[{8'h00, data_zp}] = b;
        put_two(opc, data_zp);
        data_zp = data_zp + 8'd1;
    end else
        put_two(opc, b);
    case (opc[7:5])
        3'b011: model_add(b);
        3'b111: model_add(~b);
        3'b001: begin m_a = m_a & b; model_nz(m_a); end
        3'b000: begin m_a = m_a | b; model_nz(m_a); end
        3'b010: begin m_a = m_a ^ b; model_nz(m_a); end
        default: begin                                  // CMP keeps A
            s   = {1'b0, m_a} + {1'b0, ~b} + 9'd1;
            m_c = s[8];
            model_nz(s[7:0]);
        end
    endcase
    store_zp(8'h85, m_a);
    check_all_flags();
endtask

task automatic build_program();
    cpu_pkg::byte_t r;
    for (int i = 0; i < 65536; i++)
        mem[i] = i[7:0] ^ i[15:8] ^ 8'h5A;              // Fill depends on whole address
    asm_pc   = RESET_PC;
    next_zp  = 8'h20;
    data_zp  = 8'h90;
    next_abs = 16'h0600;
    m_v      = 1'b0;
    for (int i = 0; i < 3; i++) begin
        mem[16'h0080 + i] = 8'($urandom);
        mem[16'h0680 + i] = 8'($urandom);
    end
    // Page-crossing branches, forward then back
    put_byte(8'h18);
    m_c = 1'b0;
    r = 8'($urandom);
    put_two(8'hA9, r);
    m_a = r;
    put_byte(8'h4C);
    put_two(8'hF8, 8'h02);
    asm_pc = 16'h02F8;
    put_two(8'h90, 8'h10);                              // BCC to 0x030A
    put_two(8'h85, 8'hF0);
    asm_pc = 16'h02FC;
    store_zp(8'h85, m_a);
    put_byte(8'h4C);
    put_two(8'h10, 8'h03);
    asm_pc = 16'h030A;
    put_two(8'h90, 8'hF0);                              // BCC back to 0x02FC
    put_two(8'h85, 8'hF0);
    put_two(8'h85, 8'hF0);
    asm_pc = 16'h0310;
    // Loads in all three modes, then stores
    r = 8'($urandom);
    put_two(8'hA2, r);
    m_x = r;
    store_zp(8'h86, m_x);
    r = 8'($urandom);
    put_two(8'hA0, r);
    m_y = r;
    store_zp(8'h84, m_y);
    put_two(8'hA5, 8'h80);
    m_a = mem[16'h0080];
    model_nz(m_a);
    check_flag(2'd0, m_n);
    check_flag(2'd3, m_z);
    store_abs(8'h8D, m_a);
    put_two(8'hA6, 8'h81);
    store_abs(8'h8E, mem[16'h0081]);
    put_two(8'hA4, 8'h82);
    store_abs(8'h8C, mem[16'h0082]);
    put_byte(8'hAD);
    put_two(8'h80, 8'h06);
    store_zp(8'h85, mem[16'h0680]);
    put_byte(8'hAE);
    put_two(8'h81, 8'h06);
    store_zp(8'h86, mem[16'h0681]);
    put_byte(8'hAC);
    put_two(8'h82, 8'h06);
    store_zp(8'h84, mem[16'h0682]);
    // Arithmetic and logic, random and edge operands
    alu_case(8'h69, 1'b0, 8'($urandom), 8'($urandom));
    alu_case(8'h65, 1'b1, 8'($urandom), 8'($urandom));
    alu_case(8'hE9, 1'b1, 8'($urandom), 8'($urandom));
    alu_case(8'hE5, 1'b0, 8'($urandom), 8'($urandom));
    alu_case(8'h69, 1'b0, 8'h7F, 8'h01);                // Signed overflow
    alu_case(8'hE9, 1'b1, 8'h80, 8'h01);
    alu_case(8'h29, 1'b0, 8'($urandom), 8'($urandom));
    alu_case(8'h05, 1'b1, 8'($urandom), 8'($urandom));
    alu_case(8'h49, 1'b0, 8'($urandom), 8'($urandom));
    alu_case(8'hC9, 1'b0, 8'($urandom), 8'($urandom));
    r = 8'($urandom);
    alu_case(8'hC5, 1'b0, r, r);                        // Equal compare
    // Transfers and index steps with wrap
    put_two(8'hA9, 8'hFF);
    put_byte(8'hAA);                                    // TAX
    put_byte(8'hE8);                                    // INX wraps to 00
    store_zp(8'h86, 8'h00);
    m_a = 8'hFF;
    model_nz(8'h00);
    check_flag(2'd3, m_z);
    put_two(8'hA0, 8'h00);
    put_byte(8'h88);                                    // DEY wraps to FF
    put_byte(8'h98);                                    // TYA
    m_a = 8'hFF;
    model_nz(m_a);
    store_zp(8'h85, m_a);
    check_flag(2'd0, m_n);
    r = 8'($urandom);
    put_two(8'hA9, r);
    put_byte(8'hA8);                                    // TAY
    put_byte(8'hC8);                                    // INY
    put_byte(8'hCA);                                    // DEX
    put_byte(8'h8A);                                    // TXA
    store_zp(8'h84, r + 8'd1);
    store_zp(8'h85, 8'hFF);
    final_pc = asm_pc;
    put_byte(8'h4C);
    put_two(final_pc[7:0], final_pc[15:8]);
endtask

//--- tb_cpu.sv
// Testbench for the reduced 6502-style core
// Memory is synchronous and only moves while rdy is high, as the core expects
// rdy is low about a quarter of the time, drawn from a fixed seed
// Any write outside the expected-store table counts as an error
`timescale 1ns/10ps

module tb_cpu;

    localparam cpu_pkg::addr_t RESET_PC = 16'h0200;
    // About 600 ready cycles of program, stretched by stalls, plus a wide margin
    localparam int WATCHDOG_CYCLES = 4000;

    logic           clk   = 1'b0;
    logic           reset = 1'b1;
    logic           rdy   = 1'b1;
    cpu_pkg::byte_t data_in = 8'h00;
    cpu_pkg::addr_t ab;
    cpu_pkg::byte_t data_out;
    logic           we;

    cpu_pkg::byte_t mem [65536];                        // 64 KB system memory
    cpu_pkg::byte_t expected_val [65536];               // Expected store values
    bit             expected_we [65536];                // Addresses allowed to be written
    bit             written [65536];
    cpu_pkg::addr_t final_pc = 16'hFFFF;                // Address of the closing JMP loop
    bit             done = 1'b0;
    int             errors = 0;

    `include "tb_program.svh"

    cpu_top #(
        .RESET_PC(RESET_PC)
    ) cpu_top_inst (
        .clk, .reset, .rdy, .data_in, .ab, .data_out, .we
    );

    initial begin
        forever #4 clk = ~clk;                          // 8 ns period
    end

    // Program load, then the memory itself
    initial begin
        void'($urandom(51));
        build_program();
        forever begin
            @(posedge clk);
            if (rdy) begin
                data_in <= mem[ab];                     // Byte of the previous address
                if (we) begin
                    mem[ab]     <= data_out;
                    written[ab] <= 1'b1;
                end
                if (!reset && ab == final_pc)
                    done = 1'b1;
            end
        end
    end

    initial begin
        repeat (16) @(negedge clk);
        reset = 1'b0;
        while (!done) begin
            @(negedge clk);
            rdy = ($urandom % 4) != 0;
        end
        @(negedge clk);
        rdy = 1'b1;
        repeat (2) @(posedge clk);
        for (int i = 0; i < 65536; i++) begin
            assert (!expected_we[i] || written[i])
            else begin
                errors++;
                $display("Missing store: address %h was never written", i[15:0]);
            end
        end
        $display("Errors: %0d", errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the program never reached its final jump loop");
        $display("Something failed");
        $finish;
    end

    a_reset_no_we: assert property (@(posedge clk) reset |-> !we)
    else begin
        errors++;
        $display("CHECK FAILED at %0t: we high during reset", $time);
    end

    a_first_ab: assert property (@(posedge clk) $fell(reset) |-> ab == RESET_PC)
    else begin
        errors++;
        $display("CHECK FAILED at %0t: first address %h after reset", $time, ab);
    end

    a_write_allowed: assert property (@(posedge clk) disable iff (reset)
        (we && rdy) |-> expected_we[ab])
    else begin
        errors++;
        $display("CHECK FAILED at %0t: write to forbidden address %h", $time, ab);
    end

    a_write_value: assert property (@(posedge clk) disable iff (reset)
        (we && rdy && expected_we[ab]) |-> data_out == expected_val[ab])
    else begin
        errors++;
        $display("CHECK FAILED at %0t: wrote %h to %h, expected %h", $time, data_out, ab,
                 expected_val[ab]);
    end

    // Bus must hold still through a stall
    a_stall_hold: assert property (@(posedge clk) disable iff (reset)
        $past(!rdy) |-> (ab == $past(ab) && we == $past(we) && data_out == $past(data_out)))
    else begin
        errors++;
        $display("CHECK FAILED at %0t: bus moved while rdy was low", $time);
    end

endmodule
